/* Makefile */
# Verilator build of the I/O write front end testbench

VERILATOR ?= verilator
TOP       ?= tb_zfront
FLAGS     ?= --binary --timing --assert
FILELIST  ?= zfront.f
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

/* tb_zfront.sv */
module tb_zfront;

	// writes issued by the whole run, used to size the watchdog
	localparam int NUM_WRITES      = 36;
	localparam int WATCHDOG_CYCLES = NUM_WRITES * 10 + 3 * 512 + 100;

	logic                       fclk;
	logic                       rst;
	logic                       iorq_n;
	logic                       wr_n;
	logic                       m1_n;
	zx_pkg::port_addr_t         a;
	logic [zx_pkg::DATA_W-1:0]  d;
	logic [zx_pkg::DATA_W-1:0]  border;
	logic [zx_pkg::TURBO_W-1:0] turbo;
	logic                       beep;

	// reference model of the port registers and sound mode
	logic [7:0] exp_border;
	logic [1:0] exp_turbo;
	logic       exp_mux;
	logic       exp_beeper;
	logic       exp_tape;
	logic       exp_covox;
	logic [7:0] exp_sample;
	logic       exp_beep;

	logic       chk;
	logic       cnt_en;
	logic       cnt_chk;
	logic [8:0] beep_cnt;

	logic [31:0] rng;
	int          error_count;
	int          test_err_base;
	int          tests_passed;
	int          tests_failed;

	zfront_top dut_i (
		.fclk   (fclk),
		.rst    (rst),
		.iorq_n (iorq_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d      (d),
		.border (border),
		.turbo  (turbo),
		.beep   (beep)
	);

	always #5 fclk = ~fclk;

	assign exp_beep = exp_mux ? exp_tape : exp_beeper;

	// beep high count over the covox window
	always @(posedge fclk) begin
		if (cnt_en)
			beep_cnt <= beep_cnt + {8'd0, beep};
		else if (!cnt_chk)
			beep_cnt <= '0;
	end

	////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string sig, input logic [15:0] expv,
		input logic [15:0] gotv);
		$display("[ERROR] %s expected 0x%h, got 0x%h at %0t", sig, expv, gotv, $time);
		error_count++;
	endtask

	a_border_chk: assert property (@(posedge fclk) disable iff (rst)
		chk |-> border == exp_border)
		else report_mismatch("border", 16'(exp_border), 16'(border));

	a_turbo_chk: assert property (@(posedge fclk) disable iff (rst)
		chk |-> turbo == exp_turbo)
		else report_mismatch("turbo", 16'(exp_turbo), 16'(turbo));

	// only meaningful while the sound stage is in beeper mode
	a_beep_chk: assert property (@(posedge fclk) disable iff (rst)
		chk && !exp_covox |-> beep == exp_beep)
		else report_mismatch("beep", 16'(exp_beep), 16'(beep));

	a_covox_chk: assert property (@(posedge fclk) disable iff (rst)
		cnt_chk |-> beep_cnt == {1'b0, exp_sample})
		else report_mismatch("beep_cnt", 16'(exp_sample), 16'(beep_cnt));

	////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] rand_byte();
		rng = xorshift32(rng);
		return rng[7:0];
	endfunction

	task automatic apply_reset();
		repeat (2) @(posedge fclk);
		rst <= 1'b0;
	endtask

	// port rules applied to the expected state
	task automatic update_model(input logic [15:0] addr, input logic [7:0] data,
		input logic m1);
		if (m1)
			return;
		if (addr[0] == 1'b0) begin
			exp_border[2:0] = data[2:0];
			exp_beeper      = data[4];
			exp_tape        = data[3];
			exp_covox       = 1'b0;
		end
		if (addr[7:0] == 8'hFB) begin
			exp_sample = data;
			exp_covox  = 1'b1;
		end
		if (addr == 16'h0FAF)
			exp_border = data;
		if (addr == 16'h20AF) begin
			exp_turbo = data[1:0];
			exp_mux   = data[5];
		end
	endtask

	task automatic check_outputs();
		@(posedge fclk);
		chk <= 1'b1;
		@(posedge fclk);
		chk <= 1'b0;
		@(posedge fclk);
	endtask

	// one z80 io cycle, m1 set means interrupt acknowledge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
		input logic m1);
		@(posedge fclk);
		a      <= addr;
		d      <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		m1_n   <= ~m1;
		repeat (4) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		repeat (6) @(posedge fclk);
		update_model(addr, data, m1);
		check_outputs();
	endtask

	task automatic write_fe();
		zx_pkg::port_addr_t pa;
		logic [7:0]         low;
		low             = rand_byte();
		pa.std.std_high = rand_byte();
		pa.std.std_low7 = low[7:1];
		pa.std.std_a0   = 1'b0;
		io_write(pa, rand_byte(), 1'b0);
	endtask

	task automatic covox_case(input logic [7:0] s);
		io_write({rand_byte(), 8'hFB}, s, 1'b0);
		@(posedge fclk);
		cnt_en <= 1'b1;
		repeat (256) @(posedge fclk);
		cnt_en  <= 1'b0;
		cnt_chk <= 1'b1;
		@(posedge fclk);
		cnt_chk <= 1'b0;
		@(posedge fclk);
	endtask

	task automatic finish_test(input string name);
		if (error_count == test_err_base) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d mismatches", name,
				error_count - test_err_base);
		end
		test_err_base = error_count;
	endtask

	////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////

	initial begin
		zx_pkg::port_addr_t pa;
		logic [7:0]         reg_b;
		fclk = 1'b0;
		rst = 1'b1;
		iorq_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		a = '0;
		d = '0;
		chk = 1'b0;
		cnt_en = 1'b0;
		cnt_chk = 1'b0;
		rng = 32'd82;
		exp_border = '0;
		exp_turbo = '0;
		exp_mux = 1'b0;
		exp_beeper = 1'b0;
		exp_tape = 1'b0;
		exp_covox = 1'b0;
		exp_sample = '0;
		error_count = 0;
		test_err_base = 0;
		tests_passed = 0;
		tests_failed = 0;

		apply_reset();
		check_outputs();
		repeat (20) @(posedge fclk);
		check_outputs();
		finish_test("reset");

		for (int i = 0; i < 8; i++)
			write_fe();
		// tapeout takes over the beep output
		io_write(16'h20AF, rand_byte() | 8'h20, 1'b0);
		for (int i = 0; i < 8; i++)
			write_fe();
		finish_test("port_fe");

		for (int i = 0; i < 4; i++)
			io_write(16'h0FAF, rand_byte(), 1'b0);
		for (int i = 0; i < 4; i++)
			io_write(16'h20AF, rand_byte(), 1'b0);
		for (int i = 0; i < 4; i++) begin
			reg_b = rand_byte();
			if (reg_b == 8'h0F || reg_b == 8'h20)
				reg_b = reg_b ^ 8'h01;
			pa.xt.xt_reg = reg_b;
			pa.xt.xt_sel = 8'hAF;
			io_write(pa, rand_byte(), 1'b0);
		end
		finish_test("extended");

		io_write({rand_byte(), 8'hFE}, rand_byte(), 1'b1);
		io_write(16'h0FAF, rand_byte(), 1'b1);
		finish_test("int_ack");

		covox_case(8'd0);
		covox_case(8'd255);
		covox_case(rand_byte());
		covox_case(rand_byte());
		write_fe();
		finish_test("covox");

		$display("tests passed %0d, tests failed %0d, mismatches %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fclk);
		$display("watchdog expired after %0d cycles, tests did not complete",
			WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* zbus_sync.sv */
module zbus_sync (
	input  logic                      fclk,
	input  logic                      rst,

	input  logic                      iorq_n,
	input  logic                      wr_n,
	input  logic                      m1_n,
	input  zx_pkg::port_addr_t        a,
	input  logic [zx_pkg::DATA_W-1:0] d,

	output logic                      io_wr_stb,
	output zx_pkg::port_addr_t        io_addr,
	output logic [zx_pkg::DATA_W-1:0] io_data
);

	localparam int MSB = zx_pkg::SYNC_STAGES - 1;

	logic [MSB:0] iorq_sr;
	logic [MSB:0] wr_sr;
	logic [MSB:0] m1_sr;

	logic iowr_cond;
	logic iowr_cond_d;
	logic iowr_rise;

	// strobes idle high, so reset fills the chains with ones
	always_ff @(posedge fclk) begin
		if (rst) begin
			iorq_sr <= '1;
			wr_sr   <= '1;
			m1_sr   <= '1;
		end else begin
			iorq_sr <= {iorq_sr[MSB-1:0], iorq_n};
			wr_sr   <= {wr_sr[MSB-1:0], wr_n};
			m1_sr   <= {m1_sr[MSB-1:0], m1_n};
		end
	end

	// io write outside of interrupt acknowledge
	assign iowr_cond = ~iorq_sr[MSB] & ~wr_sr[MSB] & m1_sr[MSB];
	assign iowr_rise = iowr_cond & ~iowr_cond_d;

	always_ff @(posedge fclk) begin
		if (rst) begin
			iowr_cond_d <= 1'b0;
			io_wr_stb   <= 1'b0;
		end else begin
			iowr_cond_d <= iowr_cond;
			io_wr_stb   <= iowr_rise;
		end
	end

	// bus is stable by now, grab it once per cycle
	always_ff @(posedge fclk) begin
		if (iowr_rise) begin
			io_addr <= a;
			io_data <= d;
		end
	end

	a_stb_single: assert property (@(posedge fclk) disable iff (rst)
		io_wr_stb |=> !io_wr_stb);

endmodule

/* zfront.f */
zx_pkg.sv
zbus_sync.sv
zport_decode.sv
zsound.sv
zfront_top.sv
tb_zfront.sv

/* zfront_top.sv */
module zfront_top (
	input  logic                       fclk,
	input  logic                       rst,

	// z80 side, asynchronous
	input  logic                       iorq_n,
	input  logic                       wr_n,
	input  logic                       m1_n,
	input  zx_pkg::port_addr_t         a,
	input  logic [zx_pkg::DATA_W-1:0]  d,

	output logic [zx_pkg::DATA_W-1:0]  border,
	output logic [zx_pkg::TURBO_W-1:0] turbo,
	output logic                       beep
);

	logic                      io_wr_stb;
	zx_pkg::port_addr_t        io_addr;
	logic [zx_pkg::DATA_W-1:0] io_data;

	logic                      beeper_wr;
	logic                      covox_wr;
	logic                      beeper_mux;
	logic [zx_pkg::DATA_W-1:0] wr_data;

	zbus_sync sync_i (
		.fclk      (fclk),
		.rst       (rst),
		.iorq_n    (iorq_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.a         (a),
		.d         (d),
		.io_wr_stb (io_wr_stb),
		.io_addr   (io_addr),
		.io_data   (io_data)
	);

	zport_decode decode_i (
		.fclk       (fclk),
		.rst        (rst),
		.io_wr_stb  (io_wr_stb),
		.io_addr    (io_addr),
		.io_data    (io_data),
		.border     (border),
		.turbo      (turbo),
		.beeper_mux (beeper_mux),
		.beeper_wr  (beeper_wr),
		.covox_wr   (covox_wr),
		.wr_data    (wr_data)
	);

	// beeper, tapeout and covox
	zsound sound_i (
		.fclk       (fclk),
		.rst        (rst),
		.beeper_wr  (beeper_wr),
		.covox_wr   (covox_wr),
		.beeper_mux (beeper_mux),
		.wr_data    (wr_data),
		.beep       (beep)
	);

endmodule

/* zport_decode.sv */
module zport_decode (
	input  logic                       fclk,
	input  logic                       rst,

	input  logic                       io_wr_stb,
	input  zx_pkg::port_addr_t         io_addr,
	input  logic [zx_pkg::DATA_W-1:0]  io_data,

	output logic [zx_pkg::DATA_W-1:0]  border,
	output logic [zx_pkg::TURBO_W-1:0] turbo,
	output logic                       beeper_mux,
	output logic                       beeper_wr,
	output logic                       covox_wr,
	output logic [zx_pkg::DATA_W-1:0]  wr_data
);

	logic hit_fe;
	logic hit_covox;
	logic hit_xt;
	logic hit_xborder;
	logic hit_sysconf;

	logic xborder_wr;
	logic sysconf_wr;

	logic [zx_pkg::DATA_W-1:0] sysconf;

	////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////

	assign hit_fe    = io_addr.std.std_a0 == zx_pkg::PORT_FE_A0;
	assign hit_covox = {io_addr.std.std_low7, io_addr.std.std_a0} == zx_pkg::PORT_COVOX_LO;

	assign hit_xt      = io_addr.xt.xt_sel == zx_pkg::XT_SEL;
	assign hit_xborder = hit_xt && io_addr.xt.xt_reg == zx_pkg::XT_BORDER;
	assign hit_sysconf = hit_xt && io_addr.xt.xt_reg == zx_pkg::XT_SYSCONF;

	// write pulses, one cycle after the bus strobe
	always_ff @(posedge fclk) begin
		if (rst) begin
			beeper_wr  <= 1'b0;
			covox_wr   <= 1'b0;
			xborder_wr <= 1'b0;
			sysconf_wr <= 1'b0;
		end else begin
			beeper_wr  <= io_wr_stb & hit_fe;
			covox_wr   <= io_wr_stb & hit_covox;
			xborder_wr <= io_wr_stb & hit_xborder;
			sysconf_wr <= io_wr_stb & hit_sysconf;
		end
	end

	always_ff @(posedge fclk) begin
		if (io_wr_stb)
			wr_data <= io_data;
	end

	////////////////////////////////////////////////////////////////////
	// border and sysconf registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			border  <= '0;
			sysconf <= '0;
		end else begin
			// #FE only touches the low border bits
			if (beeper_wr)
				border[zx_pkg::BORDER_STD_W-1:0] <= wr_data[zx_pkg::BORDER_STD_W-1:0];
			if (xborder_wr)
				border <= wr_data;
			if (sysconf_wr)
				sysconf <= wr_data;
		end
	end

	assign turbo      = sysconf[zx_pkg::TURBO_W-1:0];
	assign beeper_mux = sysconf[zx_pkg::SYSCONF_MUX_BIT];

	a_snd_excl: assert property (@(posedge fclk) disable iff (rst)
		!(beeper_wr && covox_wr));

endmodule

/* zsound.sv */
module zsound (
	input  logic                      fclk,
	input  logic                      rst,

	input  logic                      beeper_wr,
	input  logic                      covox_wr,
	input  logic                      beeper_mux,
	input  logic [zx_pkg::DATA_W-1:0] wr_data,

	output logic                      beep
);

	logic beeper_lvl;
	logic tape_lvl;
	logic covox_mode;
	logic beeper_sel;

	logic [zx_pkg::DATA_W-1:0] sample;
	logic [zx_pkg::DATA_W-1:0] acc;
	logic [zx_pkg::DATA_W:0]   acc_sum;

	always_ff @(posedge fclk) begin
		if (rst) begin
			beeper_lvl <= 1'b0;
			tape_lvl   <= 1'b0;
			covox_mode <= 1'b0;
			sample     <= '0;
		end else if (beeper_wr) begin
			beeper_lvl <= wr_data[zx_pkg::BEEP_BIT];
			tape_lvl   <= wr_data[zx_pkg::TAPE_BIT];
			covox_mode <= 1'b0;
		end else if (covox_wr) begin
			sample     <= wr_data;
			covox_mode <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////
	// first order sigma-delta with the carry out as bit stream
	////////////////////////////////////////////////////////////////////

	assign acc_sum    = {1'b0, acc} + {1'b0, sample};
	assign beeper_sel = beeper_mux ? tape_lvl : beeper_lvl;

	always_ff @(posedge fclk) begin
		if (rst) begin
			acc  <= '0;
			beep <= 1'b0;
		end else begin
			acc  <= acc_sum[zx_pkg::DATA_W-1:0];
			beep <= covox_mode ? acc_sum[zx_pkg::DATA_W] : beeper_sel;
		end
	end

	// written beeper or tape bit shows on beep two cycles after the write
	a_beeper_follow: assert property (@(posedge fclk) disable iff (rst)
		$past(beeper_wr, 2) |-> beep == ($past(beeper_mux)
			? $past(wr_data[zx_pkg::TAPE_BIT], 2)
			: $past(wr_data[zx_pkg::BEEP_BIT], 2)));

endmodule

/* zx_pkg.sv */
package zx_pkg;

	////////////////////////////////////////////////////////////////////
	// bus widths and synchroniser depth
	////////////////////////////////////////////////////////////////////

	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;
	localparam int SYNC_STAGES = 2;

	////////////////////////////////////////////////////////////////////
	// port numbers
	////////////////////////////////////////////////////////////////////

	// classic ula port only looks at a0
	localparam logic              PORT_FE_A0    = 1'b0;
	localparam logic [DATA_W-1:0] PORT_COVOX_LO = 8'hFB;

	// extended ports are #xxAF, register number in the high byte
	localparam logic [DATA_W-1:0] XT_SEL     = 8'hAF;
	localparam logic [DATA_W-1:0] XT_BORDER  = 8'h0F;
	localparam logic [DATA_W-1:0] XT_SYSCONF = 8'h20;

	////////////////////////////////////////////////////////////////////
	// bit positions in written data
	////////////////////////////////////////////////////////////////////

	localparam int BORDER_STD_W    = 3;
	localparam int TAPE_BIT        = 3;
	localparam int BEEP_BIT        = 4;
	localparam int TURBO_W         = 2;
	localparam int SYSCONF_MUX_BIT = 5;

	// one port address, two decodings
	typedef union packed {
		struct packed {
			logic [DATA_W-1:0] xt_reg;
			logic [DATA_W-1:0] xt_sel;
		} xt;
		struct packed {
			logic [DATA_W-1:0] std_high;
			logic [DATA_W-2:0] std_low7;
			logic              std_a0;
		} std;
	} port_addr_t;

endpackage
